// ==== common/rvseed_pkg.sv ====
package rvseed_pkg;

    // **************************************************
    // datapath widths.
    // **************************************************
    localparam int XLEN           = 64;
    localparam int REG_ADDR_WIDTH = 5;

    // major opcodes of the supported subset.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct3 and funct7 values used by decode.
    localparam logic [2:0] F3_ADD   = 3'b000;
    localparam logic [2:0] F3_XOR   = 3'b100;
    localparam logic [2:0] F3_OR    = 3'b110;
    localparam logic [2:0] F3_AND   = 3'b111;
    localparam logic [2:0] F3_DWORD = 3'b011;
    localparam logic [6:0] F7_BASE  = 7'b0000000;
    localparam logic [6:0] F7_SUB   = 7'b0100000;

    // ALU operation codes.
    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_XOR = 3'd4;

    // **************************************************
    // one instruction word, three encodings.
    // **************************************************
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
    } instr_u;

    // sign-extend a 12-bit immediate to the full register width.
    function automatic logic [XLEN-1:0] sext12(input logic [11:0] imm);
        return {{(XLEN-12){imm[11]}}, imm};
    endfunction

endpackage

// ==== execute/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage import rvseed_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ex_valid_in,
    input  logic [2:0]                ex_alu_op,
    input  logic [XLEN-1:0]           ex_op_a,
    input  logic [XLEN-1:0]           ex_op_b,
    input  logic [XLEN-1:0]           ex_store_data,
    input  logic [REG_ADDR_WIDTH-1:0] ex_rd_in,
    input  logic                      ex_wen_in,
    input  logic                      ex_load_in,
    input  logic                      ex_store_in,
    output logic [REG_ADDR_WIDTH-1:0] ex_rd,
    output logic                      ex_wen,
    output logic                      ex_load,
    output logic                      mem_valid_in,
    output logic [XLEN-1:0]           mem_result_in,
    output logic [XLEN-1:0]           mem_store_data,
    output logic                      mem_store_in,
    output logic [REG_ADDR_WIDTH-1:0] mem_rd_in,
    output logic                      mem_wen_in,
    output logic                      mem_load_in
);

    logic [XLEN-1:0] alu_result;

    // destination of the instruction now in EX, seen by the hazard unit.
    assign ex_rd   = ex_rd_in;
    assign ex_wen  = ex_valid_in && ex_wen_in;
    assign ex_load = ex_valid_in && ex_load_in;

    // LD and SD arrive as ALU_ADD with the offset in op_b.
    always_comb begin
        case (ex_alu_op)
            ALU_SUB: alu_result = ex_op_a - ex_op_b;
            ALU_AND: alu_result = ex_op_a & ex_op_b;
            ALU_OR:  alu_result = ex_op_a | ex_op_b;
            ALU_XOR: alu_result = ex_op_a ^ ex_op_b;
            default: alu_result = ex_op_a + ex_op_b;
        endcase
    end

    // **************************************************
    // EX/MEM register.
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid_in <= 1'b0;
            mem_wen_in   <= 1'b0;
            mem_load_in  <= 1'b0;
            mem_store_in <= 1'b0;
        end else begin
            mem_valid_in <= ex_valid_in;
            mem_wen_in   <= ex_valid_in && ex_wen_in;
            mem_load_in  <= ex_valid_in && ex_load_in;
            mem_store_in <= ex_valid_in && ex_store_in;
        end
    end

    always_ff @(posedge clk) begin
        mem_result_in  <= alu_result;
        mem_store_data <= ex_store_data;
        mem_rd_in      <= ex_rd_in;
    end

endmodule

// ==== list.f ====
common/rvseed_pkg.sv
src/reg_file.sv
src/id_stall.sv
src/id_decode.sv
execute/ex_stage.sv
src/mem_stage.sv
src/core_top.sv
test/core_tb.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module core_tb -o core_tb -f list.f \
    && ./obj_dir/core_tb | tee sim.log
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== src/core_top.sv ====
`timescale 1ns/1ps

module core_top import rvseed_pkg::*; #(
    parameter int DMEM_DEPTH = 16
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid,
    input  logic [31:0]               instr,
    output logic                      stall,
    output logic                      wb_valid,
    output logic [REG_ADDR_WIDTH-1:0] wb_addr,
    output logic [XLEN-1:0]           wb_data
);

    // **************************************************
    // decode and register read.
    // **************************************************
    logic [REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [XLEN-1:0]           rs1_data;
    logic [XLEN-1:0]           rs2_data;
    logic                      uses_rs2;
    logic                      fwd_a;
    logic                      fwd_b;

    // ID/EX contents.
    logic                      ex_valid_in;
    logic [2:0]                ex_alu_op;
    logic [XLEN-1:0]           ex_op_a;
    logic [XLEN-1:0]           ex_op_b;
    logic [XLEN-1:0]           ex_store_data;
    logic [REG_ADDR_WIDTH-1:0] ex_rd_in;
    logic                      ex_wen_in;
    logic                      ex_load_in;
    logic                      ex_store_in;
    logic [REG_ADDR_WIDTH-1:0] ex_rd;
    logic                      ex_wen;
    logic                      ex_load;

    // EX/MEM contents and MEM state.
    logic                      mem_valid_in;
    logic [XLEN-1:0]           mem_result_in;
    logic [XLEN-1:0]           mem_store_data;
    logic                      mem_store_in;
    logic [REG_ADDR_WIDTH-1:0] mem_rd_in;
    logic                      mem_wen_in;
    logic                      mem_load_in;
    logic [REG_ADDR_WIDTH-1:0] mem_rd;
    logic                      mem_wen;
    logic                      mem_load;
    logic [XLEN-1:0]           mem_result;

    id_decode id_decode_i (
        .clk, .rst_n, .instr_valid, .instr, .stall, .fwd_a, .fwd_b, .mem_result,
        .rs1_addr, .rs2_addr, .uses_rs2, .rs1_data, .rs2_data,
        .ex_valid_in, .ex_alu_op, .ex_op_a, .ex_op_b, .ex_store_data,
        .ex_rd_in, .ex_wen_in, .ex_load_in, .ex_store_in
    );

    // the MEM/WB register drives the write port.
    reg_file reg_file_i (
        .clk, .rst_n, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .wen(wb_valid), .waddr(wb_addr), .wdata(wb_data)
    );

    id_stall id_stall_i (
        .instr_valid, .rs1_addr, .rs2_addr, .uses_rs2,
        .ex_rd, .ex_wen, .ex_load, .mem_rd, .mem_wen, .mem_load,
        .stall, .fwd_a, .fwd_b
    );

    // **************************************************
    // execute, memory and writeback.
    // **************************************************
    ex_stage ex_stage_i (
        .clk, .rst_n, .ex_valid_in, .ex_alu_op, .ex_op_a, .ex_op_b, .ex_store_data,
        .ex_rd_in, .ex_wen_in, .ex_load_in, .ex_store_in, .ex_rd, .ex_wen, .ex_load,
        .mem_valid_in, .mem_result_in, .mem_store_data, .mem_store_in,
        .mem_rd_in, .mem_wen_in, .mem_load_in
    );

    mem_stage #(
        .DMEM_DEPTH(DMEM_DEPTH)
    ) mem_stage_i (
        .clk, .rst_n, .mem_valid_in, .mem_result_in, .mem_store_data, .mem_store_in,
        .mem_rd_in, .mem_wen_in, .mem_load_in, .mem_rd, .mem_wen, .mem_load, .mem_result,
        .wb_valid, .wb_addr, .wb_data
    );

endmodule

// ==== src/id_decode.sv ====
`timescale 1ns/1ps

module id_decode import rvseed_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid,
    input  logic [31:0]               instr,
    input  logic                      stall,
    input  logic                      fwd_a,
    input  logic                      fwd_b,
    input  logic [XLEN-1:0]           mem_result,
    output logic [REG_ADDR_WIDTH-1:0] rs1_addr,
    output logic [REG_ADDR_WIDTH-1:0] rs2_addr,
    output logic                      uses_rs2,
    input  logic [XLEN-1:0]           rs1_data,
    input  logic [XLEN-1:0]           rs2_data,
    output logic                      ex_valid_in,
    output logic [2:0]                ex_alu_op,
    output logic [XLEN-1:0]           ex_op_a,
    output logic [XLEN-1:0]           ex_op_b,
    output logic [XLEN-1:0]           ex_store_data,
    output logic [REG_ADDR_WIDTH-1:0] ex_rd_in,
    output logic                      ex_wen_in,
    output logic                      ex_load_in,
    output logic                      ex_store_in
);

    instr_u          iw;
    logic            accept;
    logic [2:0]      dec_alu_op;
    logic            dec_wen;
    logic            dec_load;
    logic            dec_store;
    logic            use_imm;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;

    assign iw       = instr;
    assign accept   = instr_valid && !stall;
    assign rs1_addr = iw.r_fmt.rs1;
    assign rs2_addr = iw.r_fmt.rs2;
    assign uses_rs2 = iw.r_fmt.opcode == OPC_OP || iw.r_fmt.opcode == OPC_STORE;

    // **************************************************
    // instruction decode.
    // **************************************************
    always_comb begin
        dec_alu_op = ALU_ADD;
        dec_wen    = 1'b0;
        dec_load   = 1'b0;
        dec_store  = 1'b0;
        use_imm    = 1'b1;
        imm        = sext12(iw.i_fmt.imm12);
        case (iw.r_fmt.opcode)
            OPC_OP: begin
                use_imm = 1'b0;
                if (iw.r_fmt.funct7 == F7_BASE) begin
                    dec_wen = 1'b1;
                    case (iw.r_fmt.funct3)
                        F3_ADD:  dec_alu_op = ALU_ADD;
                        F3_XOR:  dec_alu_op = ALU_XOR;
                        F3_OR:   dec_alu_op = ALU_OR;
                        F3_AND:  dec_alu_op = ALU_AND;
                        default: dec_wen = 1'b0;
                    endcase
                end else if (iw.r_fmt.funct7 == F7_SUB && iw.r_fmt.funct3 == F3_ADD) begin
                    dec_wen    = 1'b1;
                    dec_alu_op = ALU_SUB;
                end
            end
            OPC_OP_IMM: dec_wen = iw.i_fmt.funct3 == F3_ADD;
            OPC_LOAD:   dec_load = iw.i_fmt.funct3 == F3_DWORD;
            OPC_STORE: begin
                dec_store = iw.s_fmt.funct3 == F3_DWORD;
                imm       = sext12({iw.s_fmt.imm_hi, iw.s_fmt.imm_lo});
            end
            default: ;
        endcase
        // a result aimed at x0 is dropped here, so it never reaches writeback.
        if (iw.r_fmt.rd == '0) begin
            dec_wen  = 1'b0;
            dec_load = 1'b0;
        end
    end

    // operands, with the ALU result in MEM forwarded when selected.
    assign src_a = fwd_a ? mem_result : rs1_data;
    assign src_b = fwd_b ? mem_result : rs2_data;

    // **************************************************
    // ID/EX register.
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid_in <= 1'b0;
            ex_wen_in   <= 1'b0;
            ex_load_in  <= 1'b0;
            ex_store_in <= 1'b0;
        end else begin
            // a bubble enters whenever nothing is accepted.
            ex_valid_in <= accept;
            ex_wen_in   <= accept && (dec_wen || dec_load);
            ex_load_in  <= accept && dec_load;
            ex_store_in <= accept && dec_store;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_alu_op     <= dec_alu_op;
            ex_op_a       <= src_a;
            ex_op_b       <= use_imm ? imm : src_b;
            ex_store_data <= src_b;
            ex_rd_in      <= iw.r_fmt.rd;
        end
    end

endmodule

// ==== src/id_stall.sv ====
`timescale 1ns/1ps

module id_stall import rvseed_pkg::*; (
    input  logic                      instr_valid,
    input  logic [REG_ADDR_WIDTH-1:0] rs1_addr,
    input  logic [REG_ADDR_WIDTH-1:0] rs2_addr,
    input  logic                      uses_rs2,
    input  logic [REG_ADDR_WIDTH-1:0] ex_rd,
    input  logic                      ex_wen,
    input  logic                      ex_load,
    input  logic [REG_ADDR_WIDTH-1:0] mem_rd,
    input  logic                      mem_wen,
    input  logic                      mem_load,
    output logic                      stall,
    output logic                      fwd_a,
    output logic                      fwd_b
);

    logic ex_hit_a;
    logic ex_hit_b;
    logic mem_hit_a;
    logic mem_hit_b;
    logic stall_a;
    logic stall_b;

    always_comb begin
        // an ALU result or a load still in EX is not ready for decode.
        ex_hit_a  = (ex_wen || ex_load) && ex_rd != '0 && rs1_addr == ex_rd;
        ex_hit_b  = (ex_wen || ex_load) && ex_rd != '0 && rs2_addr == ex_rd && uses_rs2;
        mem_hit_a = mem_wen && mem_rd != '0 && rs1_addr == mem_rd;
        mem_hit_b = mem_wen && mem_rd != '0 && rs2_addr == mem_rd && uses_rs2;

        // load data in MEM is one cycle short of forwardable.
        stall_a = ex_hit_a || (mem_hit_a && mem_load);
        stall_b = ex_hit_b || (mem_hit_b && mem_load);
        stall   = instr_valid && (stall_a || stall_b);

        // the younger producer in EX takes priority over MEM.
        fwd_a = mem_hit_a && !mem_load && !ex_hit_a;
        fwd_b = mem_hit_b && !mem_load && !ex_hit_b;
    end

endmodule

// ==== src/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage import rvseed_pkg::*; #(
    parameter int DMEM_DEPTH = 16
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      mem_valid_in,
    input  logic [XLEN-1:0]           mem_result_in,
    input  logic [XLEN-1:0]           mem_store_data,
    input  logic                      mem_store_in,
    input  logic [REG_ADDR_WIDTH-1:0] mem_rd_in,
    input  logic                      mem_wen_in,
    input  logic                      mem_load_in,
    output logic [REG_ADDR_WIDTH-1:0] mem_rd,
    output logic                      mem_wen,
    output logic                      mem_load,
    output logic [XLEN-1:0]           mem_result,
    output logic                      wb_valid,
    output logic [REG_ADDR_WIDTH-1:0] wb_addr,
    output logic [XLEN-1:0]           wb_data
);

    localparam int ADDR_W = $clog2(DMEM_DEPTH);

    logic [XLEN-1:0]   dmem [DMEM_DEPTH];
    logic [ADDR_W-1:0] idx;

    // doubleword index, the byte offset is ignored.
    assign idx = mem_result_in[3 +: ADDR_W];

    // state of the instruction in MEM, for hazards and forwarding.
    assign mem_rd     = mem_rd_in;
    assign mem_wen    = mem_valid_in && mem_wen_in;
    assign mem_load   = mem_valid_in && mem_load_in;
    assign mem_result = mem_result_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_valid_in && mem_store_in) begin
            dmem[idx] <= mem_store_data;
        end
    end

    // **************************************************
    // MEM/WB register.
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= mem_valid_in && mem_wen_in;
    end

    always_ff @(posedge clk) begin
        wb_addr <= mem_rd_in;
        wb_data <= mem_load_in ? dmem[idx] : mem_result_in;
    end

    a_load_xor_store: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid_in |-> !(mem_load_in && mem_store_in));

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import rvseed_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [REG_ADDR_WIDTH-1:0] rs1_addr,
    input  logic [REG_ADDR_WIDTH-1:0] rs2_addr,
    output logic [XLEN-1:0]           rs1_data,
    output logic [XLEN-1:0]           rs2_data,
    input  logic                      wen,
    input  logic [REG_ADDR_WIDTH-1:0] waddr,
    input  logic [XLEN-1:0]           wdata
);

    logic [XLEN-1:0] regs [2**REG_ADDR_WIDTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads zero; a write in the same cycle bypasses the array.
    always_comb begin
        if (rs1_addr == '0)
            rs1_data = '0;
        else if (wen && waddr == rs1_addr)
            rs1_data = wdata;
        else
            rs1_data = regs[rs1_addr];

        if (rs2_addr == '0)
            rs2_data = '0;
        else if (wen && waddr == rs2_addr)
            rs2_data = wdata;
        else
            rs2_data = regs[rs2_addr];
    end

    // decode drops writes to x0 before they enter the pipeline.
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wen |-> waddr != '0);

endmodule

// ==== test/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

    localparam int          CLK_PERIOD   = 8;
    localparam int          DRIVE_DELAY  = 1;
    localparam int          DMEM_DEPTH   = 16;
    localparam int          MEM_AW       = $clog2(DMEM_DEPTH);
    localparam int          NUM_DIRECTED = 24;
    localparam int          NUM_RANDOM   = 300;
    localparam int          NUM_INSTR    = NUM_DIRECTED + NUM_RANDOM;
    localparam logic [31:0] SEED         = 32'ha79f;

    // instruction kinds for the assembler.
    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_AND  = 2;
    localparam int K_OR   = 3;
    localparam int K_XOR  = 4;
    localparam int K_ADDI = 5;
    localparam int K_LD   = 6;
    localparam int K_SD   = 7;

    typedef struct packed {
        logic [4:0]  addr;
        logic [63:0] data;
        logic [31:0] cyc;
    } wb_entry_t;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        stall;
    logic        wb_valid;
    logic [4:0]  wb_addr;
    logic [63:0] wb_data;

    // reference state, updated in program order at acceptance.
    logic [63:0] ref_regs [32];
    logic [63:0] ref_mem [DMEM_DEPTH];
    wb_entry_t   exp_q [$];
    int unsigned cycle = 0;

    core_top #(
        .DMEM_DEPTH(DMEM_DEPTH)
    ) core_top_i (
        .clk, .rst_n, .instr_valid, .instr, .stall, .wb_valid, .wb_addr, .wb_data
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // **************************************************
    // helpers.
    // **************************************************
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] assemble(input int kind, input int rd, input int rs1,
                                             input int rs2, input int imm);
        logic [4:0]  d;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [11:0] im;
        d  = 5'(rd);
        s1 = 5'(rs1);
        s2 = 5'(rs2);
        im = 12'(imm);
        case (kind)
            K_ADD:   return {7'h00, s2, s1, 3'b000, d, 7'b0110011};
            K_SUB:   return {7'h20, s2, s1, 3'b000, d, 7'b0110011};
            K_AND:   return {7'h00, s2, s1, 3'b111, d, 7'b0110011};
            K_OR:    return {7'h00, s2, s1, 3'b110, d, 7'b0110011};
            K_XOR:   return {7'h00, s2, s1, 3'b100, d, 7'b0110011};
            K_ADDI:  return {im, s1, 3'b000, d, 7'b0010011};
            K_LD:    return {im, s1, 3'b011, d, 7'b0000011};
            default: return {im[11:5], s2, s1, 3'b011, im[4:0], 7'b0100011};
        endcase
    endfunction

    // executes one instruction on the reference state and queues its writeback.
    function automatic void exec_ref(input logic [31:0] w, input int unsigned acc_cycle);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm_i;
        logic [63:0] imm_s;
        logic [63:0] addr;
        logic [63:0] res;
        logic        writes;
        wb_entry_t   e;
        opc    = w[6:0];
        rd     = w[11:7];
        f3     = w[14:12];
        f7     = w[31:25];
        a      = ref_regs[w[19:15]];
        b      = ref_regs[w[24:20]];
        imm_i  = {{52{w[31]}}, w[31:20]};
        imm_s  = {{52{w[31]}}, w[31:25], w[11:7]};
        res    = '0;
        writes = 1'b0;
        if (opc == 7'b0110011 && f7 == 7'h00) begin
            writes = 1'b1;
            case (f3)
                3'b000:  res = a + b;
                3'b100:  res = a ^ b;
                3'b110:  res = a | b;
                3'b111:  res = a & b;
                default: writes = 1'b0;
            endcase
        end else if (opc == 7'b0110011 && f7 == 7'h20 && f3 == 3'b000) begin
            res    = a - b;
            writes = 1'b1;
        end else if (opc == 7'b0010011 && f3 == 3'b000) begin
            res    = a + imm_i;
            writes = 1'b1;
        end else if (opc == 7'b0000011 && f3 == 3'b011) begin
            addr   = a + imm_i;
            res    = ref_mem[addr[3 +: MEM_AW]];
            writes = 1'b1;
        end else if (opc == 7'b0100011 && f3 == 3'b011) begin
            addr                     = a + imm_s;
            ref_mem[addr[3 +: MEM_AW]] = b;
        end
        // x0 stays zero and produces no writeback.
        if (writes && rd != 5'd0) begin
            ref_regs[rd] = res;
            e.addr       = rd;
            e.data       = res;
            e.cyc        = acc_cycle;
            exp_q.push_back(e);
        end
    endfunction

    task automatic check_eq(input logic [63:0] act, input logic [63:0] exp, input string what);
        if (act !== exp) begin
            $display("[FAIL] %0t: %s, expected %0h, got %0h", $time, what, exp, act);
            $display("Test FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // holds one instruction until accepted; a negative exp_stalls skips the count check.
    task automatic issue(input logic [31:0] word, input int exp_stalls);
        int stalls;
        stalls      = 0;
        instr_valid = 1'b1;
        instr       = word;
        @(negedge clk);
        while (stall) begin
            stalls++;
            @(negedge clk);
        end
        exec_ref(word, cycle);
        if (exp_stalls >= 0)
            check_eq(64'(stalls), 64'(exp_stalls), "stall cycles");
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic idle(input int n);
        instr_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    // **************************************************
    // stimulus.
    // **************************************************
    initial begin : stimulus
        logic [31:0] rng;
        int          kind;
        rng         = SEED;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;
        for (int i = 0; i < DMEM_DEPTH; i++) ref_mem[i] = '0;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        // independent ALU work, negative immediates included.
        issue(assemble(K_ADDI, 1, 0, 0, 100), 0);
        issue(assemble(K_ADDI, 2, 0, 0, -37), 0);
        issue(assemble(K_ADDI, 3, 0, 0, -2048), 0);
        issue(assemble(K_ADDI, 4, 0, 0, 2047), 0);
        issue(assemble(K_ADD, 5, 1, 2, 0), 0);
        issue(assemble(K_SUB, 6, 3, 4, 0), 0);
        issue(assemble(K_AND, 7, 1, 2, 0), 0);
        issue(assemble(K_OR, 5, 2, 3, 0), 0);
        issue(assemble(K_XOR, 6, 1, 4, 0), 0);
        issue(assemble(K_ADDI, 7, 2, 0, -1), 0);

        // back-to-back dependent chain, one bubble each.
        issue(assemble(K_ADDI, 1, 0, 0, 3), 0);
        issue(assemble(K_ADD, 2, 1, 1, 0), 1);
        issue(assemble(K_SUB, 3, 2, 1, 0), 1);
        issue(assemble(K_XOR, 4, 3, 2, 0), 1);
        issue(assemble(K_OR, 5, 4, 0, 0), 1);
        issue(assemble(K_AND, 6, 5, 4, 0), 1);

        // store, reload, then a load-use that waits two cycles.
        issue(assemble(K_SD, 0, 0, 6, 24), 1);
        issue(assemble(K_LD, 5, 0, 0, 24), 0);
        issue(assemble(K_ADD, 7, 5, 1, 0), 2);
        issue(assemble(K_LD, 3, 0, 0, 40), 0);

        // x0 as destination and as source.
        issue(assemble(K_ADDI, 0, 1, 0, 77), 0);
        issue(assemble(K_ADD, 0, 7, 7, 0), 0);
        issue(assemble(K_OR, 4, 0, 2, 0), 0);
        issue(assemble(K_ADD, 1, 0, 4, 0), 1);

        // random mix over x0 to x7, loads and stores within the data memory.
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rng  = xorshift(rng);
            kind = int'(rng[2:0]);
            if (kind == K_LD || kind == K_SD)
                issue(assemble(kind, int'(rng[5:3]), 0, int'(rng[11:9]),
                               int'(rng[18:12])), -1);
            else
                issue(assemble(kind, int'(rng[5:3]), int'(rng[8:6]), int'(rng[11:9]),
                               int'(rng[23:12])), -1);
        end

        idle(8);
        if (exp_q.size() == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("[FAIL] %0t: %0d writebacks never arrived", $time, exp_q.size());
            $display("Test FAILED");
            $fatal(1, "missing writebacks");
        end
    end

    // **************************************************
    // compare and watchdog.
    // **************************************************
    initial begin : compare
        wb_entry_t e;
        forever begin
            @(negedge clk);
            if (!instr_valid)
                check_eq(64'(stall), 64'd0, "stall raised without a valid instruction");
            if (wb_valid) begin
                check_eq(64'(exp_q.size() != 0), 64'd1, "writeback with none expected");
                e = exp_q.pop_front();
                check_eq(64'(wb_addr), 64'(e.addr), "writeback register");
                check_eq(wb_data, e.data, "writeback data");
                check_eq(64'(cycle), 64'(e.cyc) + 64'd3, "writeback latency");
            end
        end
    end

    initial begin : watchdog
        repeat (NUM_INSTR * 3 + 50) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles", NUM_INSTR * 3 + 50);
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

endmodule
